//--- hw/fpu_types_pkg.sv
package fpu_types_pkg;

    // ------------------------------------------------------------------
    // binary16 format
    // ------------------------------------------------------------------
    localparam int half_float_w    = 16;
    localparam int half_exponent_w = 5;
    localparam int half_fraction_w = 10;
    localparam int half_bias       = 15;

    // biased exponent of inf and nan
    localparam int half_exp_max = (1 << half_exponent_w) - 1;

    // exact product of two 11-bit significands
    localparam int prod_w = 2 * (half_fraction_w + 1);

    // significand handed to the rounder
    // leading one, 10 fraction bits, guard, round, sticky
    localparam int sig_w = half_fraction_w + 4;

    typedef logic [half_exponent_w-1:0] exp_t;
    typedef logic [half_fraction_w-1:0] mant_t;

    // ------------------------------------------------------------------
    // special result words
    // ------------------------------------------------------------------
    localparam logic [half_float_w-1:0] half_qnan = 16'h7e00; // canonical, sign 0
    localparam logic [half_float_w-1:0] half_inf  = 16'h7c00; // sign added by user
    localparam logic [half_float_w-1:0] half_zero = 16'h0000;
    localparam logic [half_float_w-1:0] half_max  = 16'h7bff; // 65504

    // ------------------------------------------------------------------
    // rounding modes, same encoding as the RISC-V frm field
    // ------------------------------------------------------------------
    typedef enum logic [2:0] {
        rm_rne = 3'd0, // nearest, ties to even
        rm_rtz = 3'd1, // toward zero
        rm_rdn = 3'd2, // toward -inf
        rm_rup = 3'd3, // toward +inf
        rm_rmm = 3'd4  // nearest, ties away from zero
    } rm_e;
    // 5..7 are reserved, the rounder treats them as rne

    // operand classes
    typedef enum logic [2:0] {
        fc_zero = 3'd0,
        fc_sub  = 3'd1,
        fc_norm = 3'd2,
        fc_inf  = 3'd3,
        fc_snan = 3'd4,
        fc_qnan = 3'd5
    } fclass_e;

endpackage

//--- hw/fp16_classify.sv
`timescale 1ns/1ns

// Splits one binary16 word into its fields and decides its class.
// lead_pos is the index of the leading one of the 11-bit significand,
// so a normal gives 10 and a subnormal gives 0..9.
module fp16_classify
    import fpu_types_pkg::*;
(
    input  logic [half_float_w-1:0]  value,
    output logic                     sign,
    output exp_t                     exp,
    output logic [half_fraction_w:0] sig,
    output fclass_e                  fclass,
    output logic [3:0]               lead_pos
);

    mant_t frac;

    always_comb begin
        sign = value[half_float_w-1];
        exp  = value[half_float_w-2 -: half_exponent_w];
        frac = value[half_fraction_w-1:0];

        // implicit bit only for a non-zero exponent field
        sig = {exp != '0, frac};

        // ------------------------------------------------------------------
        // class
        // ------------------------------------------------------------------
        if (exp == '1) begin
            if (frac == '0) begin
                fclass = fc_inf;
            end else if (frac[half_fraction_w-1]) begin
                fclass = fc_qnan; // quiet bit set
            end else begin
                fclass = fc_snan;
            end
        end else if (exp == '0) begin
            fclass = (frac == '0) ? fc_zero : fc_sub;
        end else begin
            fclass = fc_norm;
        end

        // leading one, highest set bit wins
        lead_pos = '0;
        for (int i = 0; i <= half_fraction_w; i++) begin
            if (sig[i]) begin
                lead_pos = 4'(i);
            end
        end
    end

endmodule

//--- hw/fp16_mul_core.sv
`timescale 1ns/1ns

// Special-case selection, significand product and normalization.
// res_exp is the biased exponent, zero for a subnormal result, and
// res_sig ends in the guard, round and sticky bits.
module fp16_mul_core
    import fpu_types_pkg::*;
(
    input  logic                     sign_a,
    input  logic                     sign_b,
    input  exp_t                     exp_a,
    input  exp_t                     exp_b,
    input  logic [half_fraction_w:0] sig_a,
    input  logic [half_fraction_w:0] sig_b,
    input  fclass_e                  class_a,
    input  fclass_e                  class_b,
    input  logic [3:0]               lead_a,
    input  logic [3:0]               lead_b,
    output logic                     res_sign,
    output logic signed [7:0]        res_exp,
    output logic [sig_w-1:0]         res_sig,
    output logic                     special,
    output logic [half_float_w-1:0]  special_word,
    output logic                     invalid
);

    logic nan_a, nan_b;
    logic inf_a, inf_b;
    logic zero_a, zero_b;
    logic zero_inf;

    logic [half_fraction_w:0] norm_a, norm_b;
    logic [prod_w-1:0]        prod, prod_n, prod_s;
    logic                     top;
    logic signed [7:0]        e_norm, sh;
    logic [4:0]               sh_amt;
    logic                     lost;

    // exponent of a left-aligned significand, subnormals live at 1
    function automatic logic signed [7:0] eff_exp(input exp_t e, input logic [3:0] lead);
        logic signed [7:0] base;
        base = (e == '0) ? 8'sd1 : $signed({3'b000, e});
        return base - $signed({4'b0000, 4'(half_fraction_w) - lead});
    endfunction

    // ------------------------------------------------------------------
    // special cases
    // ------------------------------------------------------------------
    always_comb begin
        nan_a    = class_a inside {fc_snan, fc_qnan};
        nan_b    = class_b inside {fc_snan, fc_qnan};
        inf_a    = class_a == fc_inf;
        inf_b    = class_b == fc_inf;
        zero_a   = class_a == fc_zero;
        zero_b   = class_b == fc_zero;
        zero_inf = (zero_a && inf_b) || (inf_a && zero_b);

        res_sign = sign_a ^ sign_b;
        invalid  = class_a == fc_snan || class_b == fc_snan || zero_inf;

        special = 1'b1;
        if (nan_a || nan_b || zero_inf) begin
            special_word = half_qnan;
        end else if (inf_a || inf_b) begin
            special_word = {res_sign, half_inf[half_float_w-2:0]};
        end else if (zero_a || zero_b) begin
            special_word = {res_sign, half_zero[half_float_w-2:0]};
        end else begin
            special      = 1'b0;
            special_word = half_zero;
        end
    end

    // ------------------------------------------------------------------
    // product and normalization
    // ------------------------------------------------------------------
    always_comb begin
        // left-align, no shift for normals
        norm_a = sig_a << (4'(half_fraction_w) - lead_a);
        norm_b = sig_b << (4'(half_fraction_w) - lead_b);

        prod   = prod_w'(norm_a) * prod_w'(norm_b); // in [2^20, 2^22)
        top    = prod[prod_w-1];
        prod_n = top ? prod : prod << 1;

        e_norm = eff_exp(exp_a, lead_a) + eff_exp(exp_b, lead_b)
                 - 8'(half_bias) + $signed({7'b0, top});

        if (e_norm < 8'sd1) begin
            // below min normal, denormalize and keep what falls out
            sh      = 8'sd1 - e_norm;
            sh_amt  = (sh > 8'(prod_w + 1)) ? 5'(prod_w + 1) : sh[4:0];
            lost    = |(prod_n & ~({prod_w{1'b1}} << sh_amt));
            prod_s  = prod_n >> sh_amt;
            res_exp = '0;
        end else begin
            sh      = '0;
            sh_amt  = '0;
            lost    = 1'b0;
            prod_s  = prod_n;
            res_exp = e_norm;
        end

        res_sig = {prod_s[prod_w-1:prod_w-sig_w+1], (|prod_s[prod_w-sig_w:0]) | lost};

        // normal-range results must carry their leading one
        assert (special || res_exp == '0 || res_sig[sig_w-1])
            else $error("fp16_mul_core: unnormalized significand at exponent %0d", res_exp);
    end

endmodule

//--- hw/fp16_round.sv
`timescale 1ns/1ns

// Rounds the core result to binary16 and raises the flags.
module fp16_round
    import fpu_types_pkg::*;
(
    input  logic                    res_sign,
    input  logic signed [7:0]       res_exp,
    input  logic [sig_w-1:0]        res_sig,
    input  logic                    special,
    input  logic [half_float_w-1:0] special_word,
    input  logic                    invalid,
    input  rm_e                     rm,
    output logic [half_float_w-1:0] word,
    output logic                    nv,
    output logic                    of,
    output logic                    uf,
    output logic                    nx
);

    logic              exact;
    logic              inc;      // increment at the result lsb
    logic              inc_wide; // same, one bit lower, for tininess
    logic [11:0]       sum;
    logic signed [8:0] exp_rnd;
    logic              tiny;
    logic              ovf_to_inf;
    exp_t              exp_fld;
    mant_t             frac;

    function automatic logic round_up(input logic sign, input logic lsb, input logic guard,
                                      input logic sticky, input rm_e mode);
        case (mode)
            rm_rtz:  return 1'b0;
            rm_rdn:  return sign & (guard | sticky);
            rm_rup:  return ~sign & (guard | sticky);
            rm_rmm:  return guard;
            default: return guard & (sticky | lsb); // rne, reserved codes too
        endcase
    endfunction

    always_comb begin
        exact = res_sig[2:0] == '0;
        inc   = round_up(res_sign, res_sig[3], res_sig[2], |res_sig[1:0], rm);
        sum   = {1'b0, res_sig[sig_w-1:3]} + 12'(inc);

        // carry out of the fraction bumps the exponent,
        // for a subnormal it lands on the min normal
        if (res_exp == '0) begin
            exp_rnd = {8'd0, sum[half_fraction_w]};
        end else begin
            exp_rnd = {res_exp[7], res_exp} + {8'd0, sum[half_fraction_w+1]};
        end
        frac    = sum[half_fraction_w+1] ? sum[half_fraction_w:1] : sum[half_fraction_w-1:0];
        exp_fld = exp_rnd[half_exponent_w-1:0];

        // tiny after rounding, as if the exponent were unbounded
        // only a shift by one can still reach 2^-14 there
        inc_wide = round_up(res_sign, res_sig[2], res_sig[1], res_sig[0], rm);
        tiny     = (res_exp == '0) && !((&res_sig[sig_w-2:2]) && inc_wide);

        case (rm)
            rm_rtz:  ovf_to_inf = 1'b0;
            rm_rdn:  ovf_to_inf = res_sign;
            rm_rup:  ovf_to_inf = ~res_sign;
            default: ovf_to_inf = 1'b1;
        endcase

        // ------------------------------------------------------------------
        // result word and flags
        // ------------------------------------------------------------------
        nv = 1'b0;
        of = 1'b0;
        uf = 1'b0;
        nx = 1'b0;
        if (special) begin
            word = special_word; // already exact
            nv   = invalid;
        end else if (exp_rnd >= 9'(half_exp_max)) begin
            of   = 1'b1;
            nx   = 1'b1;
            word = ovf_to_inf ? {res_sign, half_inf[half_float_w-2:0]}
                              : {res_sign, half_max[half_float_w-2:0]};
        end else begin
            word = {res_sign, exp_fld, frac};
            nx   = ~exact;
            uf   = tiny & ~exact;
        end

        // a subnormal from the core has its leading one shifted out
        assert (special || res_exp != '0 || !res_sig[sig_w-1])
            else $error("fp16_round: subnormal input with its leading one set");
    end

endmodule

//--- hw/fp16_mul_unit.sv
`timescale 1ns/1ns

// binary16 multiplier, fixed latency of two cycles after the input register
module fp16_mul_unit
    import fpu_types_pkg::*;
(
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    in_valid,
    input  logic [half_float_w-1:0] a,
    input  logic [half_float_w-1:0] b,
    input  rm_e                     rm,
    output logic                    out_valid,
    output logic [half_float_w-1:0] product,
    output logic                    flag_nv,
    output logic                    flag_of,
    output logic                    flag_uf,
    output logic                    flag_nx
);

    // stage 0, input register
    logic                    s0_valid;
    logic [half_float_w-1:0] s0_a, s0_b;
    rm_e                     s0_rm;

    // classify outputs
    logic                     cl_sign_a, cl_sign_b;
    exp_t                     cl_exp_a, cl_exp_b;
    logic [half_fraction_w:0] cl_sig_a, cl_sig_b;
    fclass_e                  cl_class_a, cl_class_b;
    logic [3:0]               cl_lead_a, cl_lead_b;

    // core outputs
    logic                    c_sign;
    logic signed [7:0]       c_exp;
    logic [sig_w-1:0]        c_sig;
    logic                    c_special;
    logic [half_float_w-1:0] c_word;
    logic                    c_invalid;

    // stage 1
    logic                    s1_valid;
    logic                    s1_sign;
    logic signed [7:0]       s1_exp;
    logic [sig_w-1:0]        s1_sig;
    logic                    s1_special;
    logic [half_float_w-1:0] s1_word;
    logic                    s1_invalid;
    rm_e                     s1_rm;

    // rounder outputs
    logic [half_float_w-1:0] r_word;
    logic                    r_nv, r_of, r_uf, r_nx;

    // ------------------------------------------------------------------
    // valid pipeline and output register
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s0_valid  <= 1'b0;
            s1_valid  <= 1'b0;
            out_valid <= 1'b0;
            product   <= '0;
            flag_nv   <= 1'b0;
            flag_of   <= 1'b0;
            flag_uf   <= 1'b0;
            flag_nx   <= 1'b0;
        end else begin
            s0_valid  <= in_valid;
            s1_valid  <= s0_valid;
            out_valid <= s1_valid;
            if (s1_valid) begin // hold last result when idle
                product <= r_word;
                flag_nv <= r_nv;
                flag_of <= r_of;
                flag_uf <= r_uf;
                flag_nx <= r_nx;
            end
        end
    end

    // payload stages
    always_ff @(posedge clk) begin
        if (in_valid) begin
            s0_a  <= a;
            s0_b  <= b;
            s0_rm <= rm;
        end
        if (s0_valid) begin
            s1_sign    <= c_sign;
            s1_exp     <= c_exp;
            s1_sig     <= c_sig;
            s1_special <= c_special;
            s1_word    <= c_word;
            s1_invalid <= c_invalid;
            s1_rm      <= s0_rm;
        end
    end

    // ------------------------------------------------------------------
    // datapath
    // ------------------------------------------------------------------
    fp16_classify classify_a_i (
        .value    (s0_a),
        .sign     (cl_sign_a),
        .exp      (cl_exp_a),
        .sig      (cl_sig_a),
        .fclass   (cl_class_a),
        .lead_pos (cl_lead_a)
    );

    fp16_classify classify_b_i (
        .value    (s0_b),
        .sign     (cl_sign_b),
        .exp      (cl_exp_b),
        .sig      (cl_sig_b),
        .fclass   (cl_class_b),
        .lead_pos (cl_lead_b)
    );

    fp16_mul_core mul_core_i (
        .sign_a       (cl_sign_a),
        .sign_b       (cl_sign_b),
        .exp_a        (cl_exp_a),
        .exp_b        (cl_exp_b),
        .sig_a        (cl_sig_a),
        .sig_b        (cl_sig_b),
        .class_a      (cl_class_a),
        .class_b      (cl_class_b),
        .lead_a       (cl_lead_a),
        .lead_b       (cl_lead_b),
        .res_sign     (c_sign),
        .res_exp      (c_exp),
        .res_sig      (c_sig),
        .special      (c_special),
        .special_word (c_word),
        .invalid      (c_invalid)
    );

    fp16_round round_i (
        .res_sign     (s1_sign),
        .res_exp      (s1_exp),
        .res_sig      (s1_sig),
        .special      (s1_special),
        .special_word (s1_word),
        .invalid      (s1_invalid),
        .rm           (s1_rm),
        .word         (r_word),
        .nv           (r_nv),
        .of           (r_of),
        .uf           (r_uf),
        .nx           (r_nx)
    );

    // an invalid operation always returns the canonical nan
    assert property (@(posedge clk) disable iff (!arst_n)
        out_valid && flag_nv |-> product == half_qnan);
    // no nan other than the canonical one leaves the unit
    assert property (@(posedge clk) disable iff (!arst_n)
        out_valid && (&product[14:10]) && (|product[9:0]) |-> product == half_qnan);

endmodule

//--- dv/fp16_clk_gen.sv
`timescale 1ns/1ns

// testbench clock and power-on reset
module fp16_clk_gen #(
    parameter int period_ns    = 8,
    parameter int reset_cycles = 5
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    initial begin
        arst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk) arst_n = 1'b1; // release away from the sampling edge
    end

endmodule

//--- dv/fp16_ref_model.svh
`ifndef FP16_REF_MODEL_SVH
`define FP16_REF_MODEL_SVH

// ----------------------------------------------------------------------
// stimulus source, 24-bit Fibonacci LFSR
// ----------------------------------------------------------------------
logic [23:0] lfsr_state = 24'd75620;

function automatic logic lfsr_step();
    logic fb;
    fb = lfsr_state[23] ^ lfsr_state[22] ^ lfsr_state[21] ^ lfsr_state[16];
    lfsr_state = {lfsr_state[22:0], fb};
    return fb;
endfunction

function automatic logic [15:0] lfsr_bits(input int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        v = {v[14:0], lfsr_step()}; // one step per bit
    end
    return v;
endfunction

// ----------------------------------------------------------------------
// reference arithmetic on integer significands
// ----------------------------------------------------------------------
// drops sh low bits of m, rounding by mode
function automatic longint round_shift(input longint m, input int sh, input logic sign,
                                       input logic [2:0] mode, output logic inexact);
    longint q;
    longint rem;
    longint half;
    logic   inc;
    int     s;
    if (sh <= 0) begin
        inexact = 1'b0;
        return m <<< (-sh);
    end
    s    = (sh > 40) ? 40 : sh; // m stays below 2^23
    q    = m >>> s;
    rem  = m - (q <<< s);
    half = longint'(1) <<< (s - 1);
    inexact = rem != 0;
    case (mode)
        3'd1:    inc = 1'b0;
        3'd2:    inc = sign && inexact;
        3'd3:    inc = !sign && inexact;
        3'd4:    inc = rem >= half;
        default: inc = (rem > half) || (rem == half && q[0]);
    endcase
    return q + longint'(inc);
endfunction

// flags come back as {nv, of, uf, nx}
function automatic logic [15:0] ref_mul(input logic [15:0] a, input logic [15:0] b,
                                        input logic [2:0] mode, output logic [3:0] flags);
    logic   s, nan_a, nan_b, snan, inf_a, inf_b, zero_a, zero_b, zi;
    logic   nx, nx2, to_inf;
    longint ma, mb, m, q, q2;
    int     ea, eb, e, p, eu, eu2;
    s      = a[15] ^ b[15];
    nan_a  = a[14:10] == 5'h1f && a[9:0] != 0;
    nan_b  = b[14:10] == 5'h1f && b[9:0] != 0;
    snan   = (nan_a && !a[9]) || (nan_b && !b[9]);
    inf_a  = a[14:10] == 5'h1f && a[9:0] == 0;
    inf_b  = b[14:10] == 5'h1f && b[9:0] == 0;
    zero_a = a[14:0] == 0;
    zero_b = b[14:0] == 0;
    zi     = (zero_a && inf_b) || (inf_a && zero_b);
    flags  = 4'b0000;
    if (nan_a || nan_b || zi) begin
        flags[3] = snan || zi;
        return 16'h7e00;
    end
    if (inf_a || inf_b) return {s, 15'h7c00};
    if (zero_a || zero_b) return {s, 15'h0000};

    // value = m * 2^e
    ma = (a[14:10] != 0) ? 1024 + longint'(a[9:0]) : longint'(a[9:0]);
    mb = (b[14:10] != 0) ? 1024 + longint'(b[9:0]) : longint'(b[9:0]);
    ea = (a[14:10] != 0) ? int'(a[14:10]) - 25 : -24;
    eb = (b[14:10] != 0) ? int'(b[14:10]) - 25 : -24;
    m  = ma * mb;
    e  = ea + eb;
    p  = 0;
    for (int i = 0; i < 24; i++) begin
        if (m[i]) p = i;
    end

    eu = (p + e < -14) ? -14 : p + e;
    q  = round_shift(m, eu - 10 - e, s, mode, nx);
    if (q == 2048) begin
        q  = 1024;
        eu = eu + 1;
    end

    // tininess with an unbounded exponent
    eu2 = p + e;
    q2  = round_shift(m, p - 10, s, mode, nx2);
    if (q2 == 2048) eu2 = eu2 + 1;

    if (eu > 15) begin
        case (mode)
            3'd1:    to_inf = 1'b0;
            3'd2:    to_inf = s;
            3'd3:    to_inf = !s;
            default: to_inf = 1'b1;
        endcase
        flags = 4'b0101;
        return to_inf ? {s, 15'h7c00} : {s, 15'h7bff};
    end
    flags = {1'b0, 1'b0, (eu2 < -14) && nx, nx};
    if (q >= 1024) return {s, 5'(eu + 15), q[9:0]};
    return {s, 5'b00000, q[9:0]};
endfunction

// ----------------------------------------------------------------------
// compare tasks
// ----------------------------------------------------------------------
task automatic check_word(input string name, input logic [half_float_w-1:0] expected,
                          input logic [half_float_w-1:0] actual);
    if (actual !== expected) begin
        error_count++;
        $display("Fail %s: product expected %h, actual %h", name, expected, actual);
    end
endtask

task automatic check_flags(input string name, input logic [3:0] expected,
                           input logic [3:0] actual);
    if (actual !== expected) begin
        error_count++;
        $display("Fail %s: flags nv/of/uf/nx expected %b, actual %b", name, expected, actual);
    end
endtask

task automatic check_valid(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
        error_count++;
        $display("Fail %s: out_valid expected %b, actual %b", name, expected, actual);
    end
endtask

`endif

//--- dv/fp16_mul_unit_tb.sv
`timescale 1ns/1ns

module fp16_mul_unit_tb
    import fpu_types_pkg::*;
;

    localparam int n_mode_ops    = 5 * 22; // directed pairs under all modes
    localparam int n_special_ops = 10;
    localparam int n_stream_ops  = 72;
    localparam int n_ops         = n_mode_ops + n_special_ops + n_stream_ops;
    localparam int watchdog_ns   = (n_ops * 20 + 5) * 8;

    // directed head of the stream, the rest comes from the LFSR
    localparam int          n_stream_head = 8;
    localparam logic [15:0] stream_x[n_stream_head] = '{16'h3c00, 16'h7c01, 16'h7bff,
        16'h0001, 16'h8000, 16'h3fff, 16'h0000, 16'hc248};
    localparam logic [15:0] stream_y[n_stream_head] = '{16'h4000, 16'h3c00, 16'h7bff,
        16'h3800, 16'h4000, 16'h3c01, 16'h7c00, 16'h417d};
    localparam logic [2:0]  stream_m[n_stream_head] = '{3'd0, 3'd0, 3'd1, 3'd3,
        3'd2, 3'd4, 3'd0, 3'd2};

    logic                    clk;
    logic                    arst_n;
    logic                    in_valid;
    logic [half_float_w-1:0] a, b;
    rm_e                     rm;
    logic                    out_valid;
    logic [half_float_w-1:0] product;
    logic                    flag_nv, flag_of, flag_uf, flag_nx;
    int                      error_count = 0;

    `include "fp16_ref_model.svh"

    fp16_clk_gen clk_gen_i (
        .clk    (clk),
        .arst_n (arst_n)
    );

    fp16_mul_unit fp16_mul_unit_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .a         (a),
        .b         (b),
        .rm        (rm),
        .out_valid (out_valid),
        .product   (product),
        .flag_nv   (flag_nv),
        .flag_of   (flag_of),
        .flag_uf   (flag_uf),
        .flag_nx   (flag_nx)
    );

    // ------------------------------------------------------------------
    // single operation, result two edges after the sampling edge
    // ------------------------------------------------------------------
    task automatic run_op(input string name, input logic [15:0] x, input logic [15:0] y,
                          input logic [2:0] mode);
        logic [15:0] exp_w;
        logic [3:0]  exp_f;
        string       tag;
        exp_w = ref_mul(x, y, mode, exp_f);
        tag   = $sformatf("%s %h*%h rm%0d", name, x, y, mode);
        @(negedge clk);
        in_valid = 1'b1;
        a        = x;
        b        = y;
        rm       = rm_e'(mode);
        @(negedge clk);
        in_valid = 1'b0;
        @(negedge clk);
        @(negedge clk);
        check_valid(tag, 1'b1, out_valid);
        check_word(tag, exp_w, product);
        check_flags(tag, exp_f, {flag_nv, flag_of, flag_uf, flag_nx});
    endtask

    task automatic run_all_modes(input string name, input logic [15:0] x, input logic [15:0] y);
        for (int m = 0; m < 5; m++) begin
            run_op(name, x, y, 3'(m));
        end
    endtask

    task automatic test_normal();
        run_all_modes("normal", 16'h3c00, 16'h4000); // exact 2.0
        run_all_modes("normal", 16'h3c01, 16'h3e00); // tie, odd neighbour below
        run_all_modes("normal", 16'h3c03, 16'h3e00); // tie the other way
        run_all_modes("normal", 16'hbc01, 16'h3e00);
        run_all_modes("normal", 16'h3bfe, 16'h3c01); // carry into exponent
        run_all_modes("normal", 16'h3bff, 16'h3c01);
        run_all_modes("normal", 16'h4248, 16'hc17d);
    endtask

    task automatic test_subnormal();
        run_all_modes("subnormal", 16'h0001, 16'h3c00);
        run_all_modes("subnormal", 16'h0200, 16'h3800);
        run_all_modes("subnormal", 16'h0001, 16'h3800); // half of min subnormal
        run_all_modes("subnormal", 16'h8001, 16'h3800);
        run_all_modes("subnormal", 16'h0400, 16'h3bff); // just below min normal
        run_all_modes("subnormal", 16'h0001, 16'h0001); // total underflow
        run_all_modes("subnormal", 16'h1000, 16'h1000);
        run_all_modes("subnormal", 16'h0155, 16'h4400);
        run_all_modes("subnormal", 16'h03ff, 16'h3c01);
        run_all_modes("subnormal", 16'h0123, 16'h5a0f);
        run_all_modes("subnormal", 16'h2123, 16'h1a0f);
    endtask

    task automatic test_overflow();
        run_all_modes("overflow", 16'h7bff, 16'h7bff);
        run_all_modes("overflow", 16'hfbff, 16'h7bff);
        run_all_modes("overflow", 16'h5c00, 16'h5c00); // 65536
        run_all_modes("overflow", 16'h5bff, 16'hdc00);
    endtask

    task automatic test_special();
        run_op("special", 16'h0000, 16'h3c00, 3'd0);
        run_op("special", 16'h8000, 16'h3c00, 3'd2);
        run_op("special", 16'h7c00, 16'h4000, 3'd0);
        run_op("special", 16'hfc00, 16'h7c00, 3'd1);
        run_op("special", 16'h7c00, 16'h0000, 3'd0); // zero times inf
        run_op("special", 16'h8000, 16'hfc00, 3'd3);
        run_op("special", 16'h7e00, 16'h3c00, 3'd0);
        run_op("special", 16'h7c01, 16'h3c00, 3'd0); // signaling
        run_op("special", 16'h3c00, 16'hfd00, 3'd4);
        run_op("special", 16'hfe00, 16'h0000, 3'd0);
    endtask

    // ------------------------------------------------------------------
    // one operation per cycle, results checked in order
    // ------------------------------------------------------------------
    task automatic test_stream();
        logic [15:0] xs[n_stream_ops];
        logic [15:0] ys[n_stream_ops];
        logic [2:0]  ms[n_stream_ops];
        logic [15:0] exp_w;
        logic [3:0]  exp_f;
        string       tag;
        for (int i = 0; i < n_stream_ops; i++) begin
            if (i < n_stream_head) begin
                xs[i] = stream_x[i];
                ys[i] = stream_y[i];
                ms[i] = stream_m[i];
            end else begin
                xs[i] = lfsr_bits(16);
                ys[i] = lfsr_bits(16);
                ms[i] = 3'(lfsr_bits(3) % 5);
            end
        end
        // a result shows up at the third falling edge after its drive
        for (int j = 0; j <= n_stream_ops + 3; j++) begin
            @(negedge clk);
            if (j >= 3 && j - 3 < n_stream_ops) begin
                exp_w = ref_mul(xs[j-3], ys[j-3], ms[j-3], exp_f);
                tag   = $sformatf("stream %0d %h*%h rm%0d", j - 3, xs[j-3], ys[j-3], ms[j-3]);
                check_valid(tag, 1'b1, out_valid);
                check_word(tag, exp_w, product);
                check_flags(tag, exp_f, {flag_nv, flag_of, flag_uf, flag_nx});
            end else begin
                check_valid("stream idle", 1'b0, out_valid);
            end
            if (j < n_stream_ops) begin
                in_valid = 1'b1;
                a        = xs[j];
                b        = ys[j];
                rm       = rm_e'(ms[j]);
            end else begin
                in_valid = 1'b0;
            end
        end
    endtask

    // ------------------------------------------------------------------
    // main sequence and watchdog
    // ------------------------------------------------------------------
    initial begin
        in_valid = 1'b0;
        a        = '0;
        b        = '0;
        rm       = rm_rne;
        @(posedge arst_n);
        @(negedge clk);
        check_valid("after reset", 1'b0, out_valid);
        check_word("after reset", 16'h0000, product);
        check_flags("after reset", 4'b0000, {flag_nv, flag_of, flag_uf, flag_nx});
        test_normal();
        test_subnormal();
        test_overflow();
        test_special();
        test_stream();
        repeat (2) @(negedge clk);
        $display("errors: %0d", error_count);
        if (error_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        #(watchdog_ns);
        $display("watchdog expired before the tests finished, errors so far: %0d", error_count);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

//--- compile.f
+incdir+dv
hw/fpu_types_pkg.sv
hw/fp16_classify.sv
hw/fp16_mul_core.sv
hw/fp16_round.sv
hw/fp16_mul_unit.sv
dv/fp16_clk_gen.sv
dv/fp16_mul_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds and runs the fp16 multiplier testbench with Verilator

cd "$(dirname "$0")" || exit 1

top=fp16_mul_unit_tb
obj=obj_dir
log=sim.log

verilator --binary --timing --assert \
    -f compile.f \
    --top-module "$top" \
    -Mdir "$obj"
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

"./$obj/V$top" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "ALL CHECKS PASSED" "$log"; then
    echo "result: pass"
    exit 0
else
    echo "result: fail"
    exit 1
fi
